// ==== logic/wisc_defs.svh ====
/*
 * shared widths, opcodes and select encodings for the
 * wisc decode slice
 */
`ifndef WISC_DEFS_SVH
`define WISC_DEFS_SVH

`define WORD_WIDTH   16  // data and instruction width
`define REG_COUNT    8   // architectural registers

// opcodes live in instruction[15:11]
`define OP_HALT   5'b00000
`define OP_NOP    5'b00001
`define OP_J      5'b00100
`define OP_JAL    5'b00110
`define OP_ADDI   5'b01000
`define OP_SUBI   5'b01001
`define OP_XORI   5'b01010
`define OP_ANDNI  5'b01011
`define OP_BEQZ   5'b01100
`define OP_BNEZ   5'b01101
`define OP_ST     5'b10000
`define OP_LD     5'b10001
`define OP_SLBI   5'b10010
`define OP_STU    5'b10011
`define OP_LBI    5'b11000
`define OP_RFMT   5'b11011  // add/sub/xor/andn, picked by instruction[1:0]

`define FUNC_ADD   2'b00
`define FUNC_SUB   2'b01
`define FUNC_XOR   2'b10
`define FUNC_ANDN  2'b11

`define ALU_ADD    4'h0
`define ALU_SUB    4'h1
`define ALU_XOR    4'h2
`define ALU_ANDN   4'h3
`define ALU_PASSB  4'h4

`define BSRC_REG   2'b00  // read port 2
`define BSRC_IMM5  2'b01
`define BSRC_IMM8  2'b10
`define BSRC_ZERO  2'b11

`define DEST_RS    2'b00  // instruction[10:8]
`define DEST_RT    2'b01  // instruction[7:5]
`define DEST_RD    2'b10  // instruction[4:2]
`define DEST_R7    2'b11  // link register for jal

`endif

// ==== logic/decodePkg.sv ====
/*
 * decodePkg: vector types and packed bundles passed between
 * the decode stage, the id/ex register and execute
 */
`include "wisc_defs.svh"

package decodePkg;

   typedef logic [`WORD_WIDTH-1:0]         word;       // one data / instruction word
   typedef logic [$clog2(`REG_COUNT)-1:0]  regIndex;   // register number
   typedef logic [4:0]                     opcode;     // instruction[15:11]
   typedef logic [3:0]                     aluOpCode;  // operation sent to the alu

   // write request from the writeback stage
   typedef struct packed {
      logic    en;
      regIndex dest;
      word     data;
   } wbPort;

   typedef struct packed {
      aluOpCode   aluOp;
      logic       invA;        // sub and subi
      logic       invB;        // andn and andni
      logic       carryIn;     // completes two's complement of a
      logic       memWrt;      // st, stu
      logic       readEn;      // ld only
      logic       regWrt;
      logic [1:0] wbDataSel;   // 00 alu, 01 memory, 10 pc+2
      logic [2:0] brchSig;     // 001 beqz, 010 bnez
      logic       branchInst;
      logic       jump;        // j and jal
      logic       jal;
      logic       slbi;        // shift rs by 8 before or with imm8
      logic       stuSel;      // store data comes from rd, used by forwarding
      logic       createDump;  // halt
      logic       err;         // illegal opcode
   } ctrlBundle;

   // everything execute needs from one decoded instruction
   typedef struct packed {
      logic      valid;
      ctrlBundle ctrl;
      word       inA;
      word       inB;
      word       wrtData;   // store data
      word       imm8;
      word       imm11;     // jump displacement
      regIndex   wrtReg;
   } exBundle;

endpackage

// ==== logic/regFile.sv ====
/*
 * regFile: eight 16-bit registers, two async reads, one
 * sync write port, no write-to-read bypass
 */
`timescale 1ns/1ps
`include "wisc_defs.svh"
`default_nettype none

module regFile (
   input  logic              clk,
   input  logic              reset,
   input  decodePkg::regIndex rdSel1,
   input  decodePkg::regIndex rdSel2,
   input  decodePkg::wbPort   wb,      // from writeback
   output decodePkg::word     rdData1,
   output decodePkg::word     rdData2
);
   import decodePkg::*;

   word regs [`REG_COUNT];  // r0 is a normal register here

   // one write per cycle, new value visible next cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         regs <= '{default: '0};
      end else if (wb.en) begin
         regs[wb.dest] <= wb.data;
      end
   end

   assign rdData1 = regs[rdSel1];  // same-cycle write returns old value
   assign rdData2 = regs[rdSel2];

   // an unknown select means decode was handed garbage
   selKnown: assert property (
      @(posedge clk) disable iff (reset) !$isunknown({rdSel1, rdSel2})
   ) else $error("regFile read select is unknown");

endmodule

`default_nettype wire

// ==== logic/aluOpDecode.sv ====
/*
 * aluOpDecode: opcode plus r-format function bits to the
 * alu operation code
 */
`timescale 1ns/1ps
`include "wisc_defs.svh"
`default_nettype none

module aluOpDecode (
   input  decodePkg::opcode    op,
   input  logic [1:0]          func,   // instruction[1:0], r-format only
   output decodePkg::aluOpCode aluOp
);

   always_comb begin
      case (op)
         `OP_ADDI:  aluOp = `ALU_ADD;
         `OP_SUBI:  aluOp = `ALU_SUB;
         `OP_XORI:  aluOp = `ALU_XOR;
         `OP_ANDNI: aluOp = `ALU_ANDN;
         `OP_RFMT: begin
            case (func)
               `FUNC_ADD: aluOp = `ALU_ADD;
               `FUNC_SUB: aluOp = `ALU_SUB;
               `FUNC_XOR: aluOp = `ALU_XOR;
               default:   aluOp = `ALU_ANDN;  // FUNC_ANDN
            endcase
         end
         // effective address is rs + imm5
         `OP_ST, `OP_LD, `OP_STU: begin
            aluOp = `ALU_ADD;
         end
         // lbi passes imm8 through, slbi merges in execute
         `OP_LBI, `OP_SLBI: begin
            aluOp = `ALU_PASSB;
         end
         default: aluOp = `ALU_ADD;  // branches, jumps, halt, nop
      endcase
   end

endmodule

`default_nettype wire

// ==== logic/controlUnit.sv ====
/*
 * controlUnit: opcode to control bundle, operand and dest
 * selects, and the illegal opcode flag
 */
`timescale 1ns/1ps
`include "wisc_defs.svh"
`default_nettype none

module controlUnit (
   input  decodePkg::word       instruction,
   output decodePkg::ctrlBundle ctrl,
   output logic [1:0]           bSrc,       // inB source
   output logic                 zeroExt5,   // xori, andni
   output logic                 zeroExt8,   // slbi
   output logic [1:0]           destSel
);
   import decodePkg::*;

   opcode    op;
   aluOpCode aluOp;
   logic     illegal;

   assign op = instruction[15:11];

   aluOpDecode aluDecoder (
      .op    (op),
      .func  (instruction[1:0]),
      .aluOp (aluOp)
   );

   always_comb begin
      ctrl     = '0;           // everything off unless the opcode says so
      ctrl.aluOp = aluOp;
      bSrc     = `BSRC_ZERO;
      zeroExt5 = 1'b0;
      zeroExt8 = 1'b0;
      destSel  = `DEST_RS;
      illegal  = 1'b0;

      case (op)
         `OP_ADDI, `OP_SUBI, `OP_XORI, `OP_ANDNI: begin
            ctrl.regWrt  = 1'b1;
            ctrl.invA    = (op == `OP_SUBI);  // b - a = b + ~a + 1
            ctrl.carryIn = (op == `OP_SUBI);
            ctrl.invB    = (op == `OP_ANDNI);
            zeroExt5     = (op == `OP_XORI) || (op == `OP_ANDNI);  // logical ops
            bSrc         = `BSRC_IMM5;
            destSel      = `DEST_RT;
         end
         `OP_RFMT: begin
            ctrl.regWrt  = 1'b1;
            ctrl.invA    = (instruction[1:0] == `FUNC_SUB);
            ctrl.carryIn = (instruction[1:0] == `FUNC_SUB);
            ctrl.invB    = (instruction[1:0] == `FUNC_ANDN);
            bSrc         = `BSRC_REG;
            destSel      = `DEST_RD;
         end
         `OP_ST: begin
            ctrl.memWrt = 1'b1;
            bSrc        = `BSRC_IMM5;
         end
         `OP_LD: begin
            ctrl.readEn    = 1'b1;
            ctrl.regWrt    = 1'b1;
            ctrl.wbDataSel = 2'b01;  // memory data
            bSrc           = `BSRC_IMM5;
            destSel        = `DEST_RT;
         end
         `OP_STU: begin
            ctrl.memWrt = 1'b1;
            ctrl.regWrt = 1'b1;      // rs gets the updated address
            ctrl.stuSel = 1'b1;
            bSrc        = `BSRC_IMM5;
         end
         `OP_BEQZ, `OP_BNEZ: begin
            ctrl.branchInst = 1'b1;
            ctrl.brchSig    = (op == `OP_BEQZ) ? 3'b001 : 3'b010;
         end
         `OP_J: ctrl.jump = 1'b1;
         `OP_JAL: begin
            ctrl.jump      = 1'b1;
            ctrl.jal       = 1'b1;
            ctrl.regWrt    = 1'b1;
            ctrl.wbDataSel = 2'b10;  // link value pc+2
            destSel        = `DEST_R7;
         end
         `OP_LBI, `OP_SLBI: begin
            ctrl.regWrt = 1'b1;
            ctrl.slbi   = (op == `OP_SLBI);
            zeroExt8    = (op == `OP_SLBI);
            bSrc        = `BSRC_IMM8;
         end
         `OP_HALT: ctrl.createDump = 1'b1;
         `OP_NOP: ;                   // all defaults
         default: illegal = 1'b1;
      endcase

      // an illegal opcode must not touch state
      if (illegal) begin
         ctrl.err    = 1'b1;
         ctrl.regWrt = 1'b0;
         ctrl.memWrt = 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== logic/decode.sv ====
/*
 * decode stage: register reads, immediates, operand and
 * destination selection, NOP in place of empty slots
 */
`timescale 1ns/1ps
`include "wisc_defs.svh"
`default_nettype none

module decode (
   input  logic               clk,
   input  logic               reset,
   input  decodePkg::word     instruction,
   input  logic               instrValid,
   input  decodePkg::wbPort   wb,
   output decodePkg::exBundle next         // into id/ex
);
   import decodePkg::*;

   word       inst;              // instruction after nop substitution
   word       rdData1, rdData2;
   word       imm5, imm8, imm11;
   word       inB;
   regIndex   wrtReg;
   ctrlBundle ctrl;
   logic [1:0] bSrc, destSel;
   logic      zeroExt5, zeroExt8;

   // empty slot decodes as nop, so every enable is clear
   assign inst = instrValid ? instruction : {`OP_NOP, 11'b0};

   regFile registerFile (
      .clk     (clk),
      .reset   (reset),
      .rdSel1  (inst[10:8]),  // rs
      .rdSel2  (inst[7:5]),   // rt, also store data for st/stu
      .wb      (wb),
      .rdData1 (rdData1),
      .rdData2 (rdData2)
   );

   controlUnit instrDecoder (
      .instruction (inst),
      .ctrl        (ctrl),
      .bSrc        (bSrc),
      .zeroExt5    (zeroExt5),
      .zeroExt8    (zeroExt8),
      .destSel     (destSel)
   );

   assign imm5  = zeroExt5 ? {11'b0, inst[4:0]} : {{11{inst[4]}}, inst[4:0]};
   assign imm8  = zeroExt8 ? {8'b0, inst[7:0]} : {{8{inst[7]}}, inst[7:0]};
   assign imm11 = {{5{inst[10]}}, inst[10:0]};  // always signed

   always_comb begin
      case (destSel)
         `DEST_RS: wrtReg = inst[10:8];
         `DEST_RT: wrtReg = inst[7:5];
         `DEST_RD: wrtReg = inst[4:2];
         default:  wrtReg = 3'd7;  // jal link
      endcase
   end

   always_comb begin
      case (bSrc)
         `BSRC_REG:  inB = rdData2;
         `BSRC_IMM5: inB = imm5;
         `BSRC_IMM8: inB = imm8;
         default:    inB = '0;
      endcase
   end

   always_comb begin
      next.valid   = instrValid;
      next.ctrl    = ctrl;
      next.inA     = rdData1;
      next.inB     = inB;
      next.wrtData = ctrl.memWrt ? rdData2 : inB;  // st and stu store rd
      next.imm8    = imm8;
      next.imm11   = imm11;
      next.wrtReg  = wrtReg;
   end

endmodule

`default_nettype wire

// ==== logic/idExRegister.sv ====
/*
 * idExRegister: decode to execute pipeline register,
 * flush beats stall
 */
`timescale 1ns/1ps
`default_nettype none

module idExRegister (
   input  logic               clk,
   input  logic               reset,
   input  logic               stall,   // hold current contents
   input  logic               flush,   // insert a bubble
   input  decodePkg::exBundle next,
   output decodePkg::exBundle ex
);

   // a bubble has valid and every enable low
   always_ff @(posedge clk) begin
      if (reset || flush) begin
         ex <= '0;
      end else if (!stall) begin
         ex <= next;
      end
   end

   // a flushed slot never reaches execute as valid
   flushKills: assert property (
      @(posedge clk) disable iff (reset) flush |=> !ex.valid
   ) else $error("ex.valid set in the cycle after flush");

   // a stall freezes the whole bundle
   stallHolds: assert property (
      @(posedge clk) disable iff (reset) (stall && !flush) |=> $stable(ex)
   ) else $error("ex changed across a stall");

endmodule

`default_nettype wire

// ==== logic/decodeSlice.sv ====
/*
 * decodeSlice: decode stage followed by the id/ex register,
 * one cycle from instruction to ex
 */
`timescale 1ns/1ps
`default_nettype none

module decodeSlice (
   input  logic               clk,
   input  logic               reset,
   input  decodePkg::word     instruction,
   input  logic               instrValid,
   input  decodePkg::wbPort   wb,          // from the writeback stage
   input  logic               stall,
   input  logic               flush,
   output decodePkg::exBundle ex
);
   import decodePkg::*;

   exBundle next;  // combinational decode result

   decode decodeStage (
      .clk         (clk),
      .reset       (reset),
      .instruction (instruction),
      .instrValid  (instrValid),
      .wb          (wb),
      .next        (next)
   );

   idExRegister idEx (
      .clk   (clk),
      .reset (reset),
      .stall (stall),
      .flush (flush),
      .next  (next),
      .ex    (ex)
   );

endmodule

`default_nettype wire

// ==== testbench/decodeSliceTb.sv ====
/*
 * decodeSliceTb: random and directed instructions into the decode
 * slice, a shadow register file and reference decoder, and
 * concurrent assertions comparing every ex field one cycle later
 */
`timescale 1ns/1ps
`include "wisc_defs.svh"

module decodeSliceTb;
   import decodePkg::*;

   localparam int  RESET_CYCLES    = 4;
   localparam int  DIRECTED_CYCLES = 20;
   localparam int  RANDOM_CYCLES   = 400;
   localparam int  TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 100;
   localparam word IDLE            = {`OP_NOP, 11'b0};

   logic    clk = 1'b0;
   logic    reset, instrValid, stall, flush;
   word     instruction;
   wbPort   wb;
   exBundle ex;
   exBundle expEx = '0;      // what ex must hold after the current edge
   word     shadow [8];      // reference copy of the register file
   integer  seed = 15583;
   int      cycleCount = 0;

   // legal opcodes first, the last five are illegal
   opcode opList [21] = '{`OP_ADDI, `OP_SUBI, `OP_XORI, `OP_ANDNI, `OP_RFMT, `OP_ST, `OP_LD,
      `OP_STU, `OP_BEQZ, `OP_BNEZ, `OP_J, `OP_JAL, `OP_LBI, `OP_SLBI, `OP_HALT, `OP_NOP,
      5'b00010, 5'b00011, 5'b00101, 5'b10100, 5'b11111};

   decodeSlice i_dut (
      .clk         (clk),
      .reset       (reset),
      .instruction (instruction),
      .instrValid  (instrValid),
      .wb          (wb),
      .stall       (stall),
      .flush       (flush),
      .ex          (ex)
   );

   always #20 clk = ~clk;  // 40 ns period

   // reference decoder, straight from the opcode table
   function automatic exBundle expectFor(word instrIn, logic validIn);
      exBundle    e;
      word        instr;
      word        imm5s;
      opcode      op;
      logic [1:0] k;   // 0 add, 1 sub, 2 xor, 3 andn
      logic       isI, isR;
      instr = validIn ? instrIn : IDLE;  // empty slot behaves as nop
      op    = instr[15:11];
      imm5s = {{11{instr[4]}}, instr[4:0]};
      isI   = (op == `OP_ADDI) || (op == `OP_SUBI) || (op == `OP_XORI) || (op == `OP_ANDNI);
      isR   = (op == `OP_RFMT);
      k     = isR ? instr[1:0] : (op == `OP_SUBI) ? 2'd1 :
              (op == `OP_XORI) ? 2'd2 : (op == `OP_ANDNI) ? 2'd3 : 2'd0;
      e        = '0;
      e.valid  = validIn;
      e.inA    = shadow[instr[10:8]];
      e.imm8   = (op == `OP_SLBI) ? {8'b0, instr[7:0]} : {{8{instr[7]}}, instr[7:0]};
      e.imm11  = {{5{instr[10]}}, instr[10:0]};
      e.wrtReg = instr[10:8];  // rs unless noted below
      e.ctrl.aluOp = `ALU_ADD;
      if (isI || isR) begin
         e.ctrl.aluOp   = (k == 2'd1) ? `ALU_SUB : (k == 2'd2) ? `ALU_XOR :
                          (k == 2'd3) ? `ALU_ANDN : `ALU_ADD;
         e.ctrl.invA    = (k == 2'd1);
         e.ctrl.carryIn = (k == 2'd1);
         e.ctrl.invB    = (k == 2'd3);
         e.ctrl.regWrt  = 1'b1;
         e.inB    = isR ? shadow[instr[7:5]] : k[1] ? {11'b0, instr[4:0]} : imm5s;
         e.wrtReg = isR ? instr[4:2] : instr[7:5];
      end
      case (op)
         `OP_ST, `OP_STU: begin
            e.ctrl.memWrt = 1'b1;
            e.ctrl.regWrt = (op == `OP_STU);  // stu updates rs
            e.ctrl.stuSel = (op == `OP_STU);
            e.inB         = imm5s;
         end
         `OP_LD: begin
            e.ctrl.readEn    = 1'b1;
            e.ctrl.regWrt    = 1'b1;
            e.ctrl.wbDataSel = 2'b01;
            e.inB            = imm5s;
            e.wrtReg         = instr[7:5];
         end
         `OP_BEQZ, `OP_BNEZ: begin
            e.ctrl.branchInst = 1'b1;
            e.ctrl.brchSig    = (op == `OP_BEQZ) ? 3'b001 : 3'b010;
         end
         `OP_J: e.ctrl.jump = 1'b1;
         `OP_JAL: begin
            e.ctrl.jump      = 1'b1;
            e.ctrl.jal       = 1'b1;
            e.ctrl.regWrt    = 1'b1;
            e.ctrl.wbDataSel = 2'b10;
            e.wrtReg         = 3'd7;  // link register
         end
         `OP_LBI, `OP_SLBI: begin
            e.ctrl.regWrt = 1'b1;
            e.ctrl.slbi   = (op == `OP_SLBI);
            e.ctrl.aluOp  = `ALU_PASSB;
            e.inB         = e.imm8;
         end
         `OP_HALT: e.ctrl.createDump = 1'b1;
         `OP_NOP, `OP_ADDI, `OP_SUBI, `OP_XORI, `OP_ANDNI, `OP_RFMT: ;
         default: e.ctrl.err = 1'b1;
      endcase
      // store data is rt for st and stu, else it follows inB
      e.wrtData = (op == `OP_ST || op == `OP_STU) ? shadow[instr[7:5]] : e.inB;
      return e;
   endfunction

   // pipeline model, expectation is built before the shadow write
   always @(posedge clk) begin : model
      exBundle e;
      e = expectFor(instruction, instrValid);
      if (reset || flush) expEx <= '0;  // flush beats stall
      else if (!stall) expEx <= e;
      if (reset) begin
         foreach (shadow[i]) shadow[i] = '0;
      end else if (wb.en) begin
         shadow[wb.dest] = wb.data;
      end
   end

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("ERRORS FOUND");
         $fatal(1, "simulation timed out");
      end
   end

   task automatic mismatch(input string field, input logic [31:0] got, input logic [31:0] want);
      $display("ERR time=%0t %s dut=%h expected=%h", $time, field, got, want);
      $display("ERRORS FOUND");
      $fatal(1, "ex field mismatch");
   endtask

   task automatic drive(input word instr, input logic v, input wbPort w,
                        input logic st, input logic fl);
      @(posedge clk);
      instruction <= instr;
      instrValid  <= v;
      wb          <= w;
      stall       <= st;
      flush       <= fl;
   endtask

   validOk: assert property (@(posedge clk) disable iff (reset) ex.valid == expEx.valid)
      else mismatch("ex.valid", $sampled(ex.valid), $sampled(expEx.valid));
   ctrlOk: assert property (@(posedge clk) disable iff (reset) ex.ctrl == expEx.ctrl)
      else mismatch("ex.ctrl", $sampled(ex.ctrl), $sampled(expEx.ctrl));
   inAOk: assert property (@(posedge clk) disable iff (reset) ex.inA == expEx.inA)
      else mismatch("ex.inA", $sampled(ex.inA), $sampled(expEx.inA));
   inBOk: assert property (@(posedge clk) disable iff (reset) ex.inB == expEx.inB)
      else mismatch("ex.inB", $sampled(ex.inB), $sampled(expEx.inB));
   wrtDataOk: assert property (@(posedge clk) disable iff (reset) ex.wrtData == expEx.wrtData)
      else mismatch("ex.wrtData", $sampled(ex.wrtData), $sampled(expEx.wrtData));
   imm8Ok: assert property (@(posedge clk) disable iff (reset) ex.imm8 == expEx.imm8)
      else mismatch("ex.imm8", $sampled(ex.imm8), $sampled(expEx.imm8));
   imm11Ok: assert property (@(posedge clk) disable iff (reset) ex.imm11 == expEx.imm11)
      else mismatch("ex.imm11", $sampled(ex.imm11), $sampled(expEx.imm11));
   wrtRegOk: assert property (@(posedge clk) disable iff (reset) ex.wrtReg == expEx.wrtReg)
      else mismatch("ex.wrtReg", $sampled(ex.wrtReg), $sampled(expEx.wrtReg));

   initial begin : stimulus
      logic [31:0] r, w;
      reset       = 1'b1;
      instruction = IDLE;
      instrValid  = 1'b0;
      wb          = '0;
      stall       = 1'b0;
      flush       = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      drive({`OP_RFMT, 3'd1, 3'd2, 3'd3, `FUNC_ADD}, 1'b1, '0, 1'b0, 1'b0);  // reads zero
      drive(IDLE, 1'b0, {1'b1, 3'd1, 16'h1234}, 1'b0, 1'b0);
      drive(IDLE, 1'b0, {1'b1, 3'd2, 16'hbeef}, 1'b0, 1'b0);
      drive({`OP_RFMT, 3'd1, 3'd2, 3'd5, `FUNC_SUB}, 1'b1, '0, 1'b0, 1'b0);
      drive({`OP_ST, 3'd1, 3'd2, 5'h1f}, 1'b1, '0, 1'b0, 1'b0);
      drive({`OP_STU, 3'd2, 3'd1, 5'h04}, 1'b1, '0, 1'b0, 1'b0);
      // r1 written while read, old value first
      drive({`OP_RFMT, 3'd1, 3'd1, 3'd6, `FUNC_XOR}, 1'b1, {1'b1, 3'd1, 16'h5a5a}, 1'b0, 1'b0);
      drive({`OP_RFMT, 3'd1, 3'd1, 3'd6, `FUNC_ANDN}, 1'b1, '0, 1'b0, 1'b0);
      drive({`OP_LBI, 3'd4, 8'h80}, 1'b1, '0, 1'b0, 1'b0);
      drive({`OP_JAL, 11'h401}, 1'b1, '0, 1'b1, 1'b0);   // held by stall
      drive({`OP_J, 11'h7ff}, 1'b1, '0, 1'b1, 1'b0);
      drive({`OP_SLBI, 3'd3, 8'h9c}, 1'b1, '0, 1'b1, 1'b1);  // flush with stall
      drive({`OP_LD, 3'd2, 3'd7, 5'h10}, 1'b0, '0, 1'b0, 1'b0);  // empty slot
      drive({5'b11111, 11'h0aa}, 1'b1, '0, 1'b0, 1'b0);
      drive({`OP_HALT, 11'h0}, 1'b1, '0, 1'b0, 1'b0);
      repeat (RANDOM_CYCLES) begin
         r = $random(seed);
         w = $random(seed);
         // valid 7/8, stall 1/8, flush 1/16, write port half the time
         drive({opList[$unsigned($random(seed)) % 21], r[10:0]}, r[31:29] != 3'd0,
               {w[31], w[30:28], w[15:0]}, r[24:22] == 3'd0, r[21:18] == 4'd0);
      end
      drive(IDLE, 1'b0, '0, 1'b0, 1'b0);
      repeat (2) @(posedge clk);
      $display("NO ERRORS");
      $finish;
   end

endmodule

// ==== decodeSlice.f ====
+incdir+logic
logic/decodePkg.sv
logic/regFile.sv
logic/aluOpDecode.sv
logic/controlUnit.sv
logic/decode.sv
logic/idExRegister.sv
logic/decodeSlice.sv
testbench/decodeSliceTb.sv
